// File: rtl/exu_config.svh
// widths and constants for the execute pipeline, included by every rtl file
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// data path
`define EXU_XLEN            64
`define EXU_PC_STEP         4
`define EXU_WORD_BITS       32
`define EXU_SHAMT_BITS      6
`define EXU_WORD_SHAMT_BITS 5

// decoded control fields
`define EXU_ALU_OP_W  5
`define EXU_B_SRC_W   2
`define EXU_BRANCH_W  3
`define EXU_MEM_OP_W  3
`define EXU_EX_CTRL_W 4

`endif

// File: rtl/exu_pkg.sv
// decoded opcode and control encodings, imported by the execute rtl and its testbench
`include "exu_config.svh"

package exu_pkg;

  typedef enum logic [`EXU_ALU_OP_W-1:0] {
    alu_add    = 5'b00000,
    alu_sll    = 5'b00001,
    alu_slt    = 5'b00010,
    alu_sltu   = 5'b00011,
    alu_xor    = 5'b00100,
    alu_srl    = 5'b00101,
    alu_or     = 5'b00110,
    alu_and    = 5'b00111,
    alu_sub    = 5'b01000,
    alu_sra    = 5'b01101,
    alu_copy_b = 5'b01111
  } alu_op_e;

  typedef enum logic [`EXU_B_SRC_W-1:0] {
    b_src_rs2     = 2'b00,
    b_src_imm     = 2'b01,
    b_src_pc_step = 2'b10
  } b_src_e;

  // next pc kind, conditional branches share the 1xx space
  typedef enum logic [`EXU_BRANCH_W-1:0] {
    br_none = 3'b000,
    br_jal  = 3'b001,
    br_jalr = 3'b010,
    br_beq  = 3'b100,
    br_bne  = 3'b101,
    br_blt  = 3'b110,
    br_bge  = 3'b111
  } branch_e;

  typedef enum logic [`EXU_MEM_OP_W-1:0] {
    mem_lb  = 3'b000,
    mem_lbu = 3'b001,
    mem_lh  = 3'b010,
    mem_lhu = 3'b011,
    mem_lw  = 3'b100,
    mem_lwu = 3'b101,
    mem_ld  = 3'b110
  } mem_op_e;

  typedef enum logic [`EXU_EX_CTRL_W-1:0] {
    ex_csr_write = 4'b0000,
    ex_ebreak    = 4'b1110,
    ex_none      = 4'b1111
  } ex_ctrl_e;

endpackage

// File: rtl/exu_operand_stage.sv
// execute stage 1, cuts and selects the alu operands and registers them with the control
`include "exu_config.svh"

module exu_operand_stage import exu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_valid,
  input  logic [`EXU_XLEN-1:0] i_rs1,
  input  logic [`EXU_XLEN-1:0] i_rs2,
  input  logic [`EXU_XLEN-1:0] i_imm,
  input  logic [`EXU_XLEN-1:0] i_pc,
  input  logic                 i_a_from_pc,
  input  b_src_e               i_b_src,
  input  logic                 i_word_cut,
  input  alu_op_e              i_alu_op,
  input  branch_e              i_branch,
  input  mem_op_e              i_mem_op,
  input  logic                 i_mem_to_reg,
  input  logic [`EXU_XLEN-1:0] i_rdata,
  input  ex_ctrl_e             i_ex_ctrl,
  input  logic                 i_invalid_inst,
  input  logic                 i_sel_csr,
  output logic                 o_valid,
  output logic [`EXU_XLEN-1:0] o_src_a,
  output logic [`EXU_XLEN-1:0] o_src_b,
  output logic [`EXU_XLEN-1:0] o_rs1,
  output logic [`EXU_XLEN-1:0] o_rs2,
  output logic [`EXU_XLEN-1:0] o_imm,
  output logic [`EXU_XLEN-1:0] o_pc,
  output logic [`EXU_XLEN-1:0] o_rdata,
  output alu_op_e              o_alu_op,
  output logic                 o_word_cut,
  output branch_e              o_branch,
  output mem_op_e              o_mem_op,
  output logic                 o_mem_to_reg,
  output ex_ctrl_e             o_ex_ctrl,
  output logic                 o_invalid_inst,
  output logic                 o_sel_csr
);

  localparam int HI_BITS = `EXU_XLEN - `EXU_WORD_BITS;

  logic [`EXU_XLEN-1:0] rs1_cut;
  logic [`EXU_XLEN-1:0] rs2_cut;
  logic [`EXU_XLEN-1:0] imm_cut;
  logic [`EXU_XLEN-1:0] src_a;
  logic [`EXU_XLEN-1:0] src_b;

  // word cut keeps the low half, zero extended
  assign rs1_cut = i_word_cut ? {{HI_BITS{1'b0}}, i_rs1[`EXU_WORD_BITS-1:0]} : i_rs1;
  assign rs2_cut = i_word_cut ? {{HI_BITS{1'b0}}, i_rs2[`EXU_WORD_BITS-1:0]} : i_rs2;
  assign imm_cut = i_word_cut ? {{HI_BITS{1'b0}}, i_imm[`EXU_WORD_BITS-1:0]} : i_imm;

  assign src_a = i_a_from_pc ? i_pc : rs1_cut;

  always_comb begin
    case (i_b_src)
      b_src_imm:     src_b = imm_cut;
      b_src_pc_step: src_b = `EXU_XLEN'(`EXU_PC_STEP);
      default:       src_b = rs2_cut;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid        <= 1'b0;
      o_src_a        <= '0;
      o_src_b        <= '0;
      o_rs1          <= '0;
      o_rs2          <= '0;
      o_imm          <= '0;
      o_pc           <= '0;
      o_rdata        <= '0;
      o_alu_op       <= alu_add;
      o_word_cut     <= 1'b0;
      o_branch       <= br_none;
      o_mem_op       <= mem_lb;
      o_mem_to_reg   <= 1'b0;
      o_ex_ctrl      <= ex_none;
      o_invalid_inst <= 1'b0;
      o_sel_csr      <= 1'b0;
    end else begin
      o_valid        <= i_valid;
      o_src_a        <= src_a;
      o_src_b        <= src_b;
      // uncut copies for branch target and writeback
      o_rs1          <= i_rs1;
      o_rs2          <= i_rs2;
      o_imm          <= i_imm;
      o_pc           <= i_pc;
      o_rdata        <= i_rdata;
      o_alu_op       <= i_alu_op;
      o_word_cut     <= i_word_cut;
      o_branch       <= i_branch;
      o_mem_op       <= i_mem_op;
      o_mem_to_reg   <= i_mem_to_reg;
      o_ex_ctrl      <= i_ex_ctrl;
      o_invalid_inst <= i_invalid_inst;
      o_sel_csr      <= i_sel_csr;
    end
  end

endmodule

// File: rtl/exu_alu_stage.sv
// execute stage 2, runs the alu and the next pc logic and registers them for writeback
`include "exu_config.svh"

module exu_alu_stage import exu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_valid,
  input  logic [`EXU_XLEN-1:0] i_src_a,
  input  logic [`EXU_XLEN-1:0] i_src_b,
  input  logic [`EXU_XLEN-1:0] i_rs1,
  input  logic [`EXU_XLEN-1:0] i_rs2,
  input  logic [`EXU_XLEN-1:0] i_imm,
  input  logic [`EXU_XLEN-1:0] i_pc,
  input  logic [`EXU_XLEN-1:0] i_rdata,
  input  alu_op_e              i_alu_op,
  input  logic                 i_word_cut,
  input  branch_e              i_branch,
  input  mem_op_e              i_mem_op,
  input  logic                 i_mem_to_reg,
  input  ex_ctrl_e             i_ex_ctrl,
  input  logic                 i_invalid_inst,
  input  logic                 i_sel_csr,
  output logic                 o_valid,
  output logic [`EXU_XLEN-1:0] o_alu_result,
  output logic [`EXU_XLEN-1:0] o_next_pc,
  output logic [`EXU_XLEN-1:0] o_src_a,
  output logic [`EXU_XLEN-1:0] o_rs2,
  output logic [`EXU_XLEN-1:0] o_rdata,
  output mem_op_e              o_mem_op,
  output logic                 o_mem_to_reg,
  output ex_ctrl_e             o_ex_ctrl,
  output logic                 o_invalid_inst,
  output logic                 o_sel_csr
);

  localparam int HI_BITS = `EXU_XLEN - `EXU_WORD_BITS;

  logic [`EXU_XLEN-1:0]       diff;
  logic [`EXU_XLEN-1:0]       raw;
  logic [`EXU_XLEN-1:0]       result;
  logic [`EXU_XLEN-1:0]       pc_step;
  logic [`EXU_XLEN-1:0]       pc_imm;
  logic [`EXU_XLEN-1:0]       jalr_sum;
  logic [`EXU_XLEN-1:0]       next_pc;
  logic [`EXU_XLEN-1:0]       sra_full;
  logic [`EXU_SHAMT_BITS-1:0] shamt;
  logic [`EXU_WORD_BITS-1:0]  sra_word;
  logic                       zero;
  logic                       less;

  // -------------------------------------------------
  // alu
  // -------------------------------------------------
  assign diff = i_src_a - i_src_b;
  assign zero = (diff == '0);
  assign less = $signed(i_src_a) < $signed(i_src_b);

  assign shamt = i_word_cut ?
    {{(`EXU_SHAMT_BITS-`EXU_WORD_SHAMT_BITS){1'b0}}, i_src_b[`EXU_WORD_SHAMT_BITS-1:0]} :
    i_src_b[`EXU_SHAMT_BITS-1:0];

  // A is zero extended under the cut, so sraw shifts the low half on its own
  assign sra_word = $signed(i_src_a[`EXU_WORD_BITS-1:0]) >>> shamt;
  assign sra_full = $signed(i_src_a) >>> shamt;

  always_comb begin
    case (i_alu_op)
      alu_sub:    raw = diff;
      alu_sll:    raw = i_src_a << shamt;
      alu_slt:    raw = `EXU_XLEN'(less);
      alu_sltu:   raw = `EXU_XLEN'(i_src_a < i_src_b);
      alu_xor:    raw = i_src_a ^ i_src_b;
      alu_srl:    raw = i_src_a >> shamt;
      alu_sra:    raw = i_word_cut ? {{HI_BITS{1'b0}}, sra_word} : sra_full;
      alu_or:     raw = i_src_a | i_src_b;
      alu_and:    raw = i_src_a & i_src_b;
      alu_copy_b: raw = i_src_b;
      default:    raw = i_src_a + i_src_b;
    endcase
  end

  assign result = i_word_cut ? {{HI_BITS{raw[`EXU_WORD_BITS-1]}}, raw[`EXU_WORD_BITS-1:0]} : raw;

  // -------------------------------------------------
  // next pc
  // -------------------------------------------------
  assign pc_step  = i_pc + `EXU_XLEN'(`EXU_PC_STEP);
  assign pc_imm   = i_pc + i_imm;
  assign jalr_sum = i_rs1 + i_imm;

  always_comb begin
    case (i_branch)
      br_jal:  next_pc = pc_imm;
      br_jalr: next_pc = {jalr_sum[`EXU_XLEN-1:1], 1'b0};
      br_beq:  next_pc = zero ? pc_imm : pc_step;
      br_bne:  next_pc = zero ? pc_step : pc_imm;
      br_blt:  next_pc = less ? pc_imm : pc_step;
      br_bge:  next_pc = less ? pc_step : pc_imm;
      default: next_pc = pc_step;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid        <= 1'b0;
      o_alu_result   <= '0;
      o_next_pc      <= '0;
      o_src_a        <= '0;
      o_rs2          <= '0;
      o_rdata        <= '0;
      o_mem_op       <= mem_lb;
      o_mem_to_reg   <= 1'b0;
      o_ex_ctrl      <= ex_none;
      o_invalid_inst <= 1'b0;
      o_sel_csr      <= 1'b0;
    end else begin
      o_valid        <= i_valid;
      o_alu_result   <= result;
      o_next_pc      <= next_pc;
      o_src_a        <= i_src_a;
      o_rs2          <= i_rs2;
      o_rdata        <= i_rdata;
      o_mem_op       <= i_mem_op;
      o_mem_to_reg   <= i_mem_to_reg;
      o_ex_ctrl      <= i_ex_ctrl;
      o_invalid_inst <= i_invalid_inst;
      o_sel_csr      <= i_sel_csr;
    end
  end

endmodule

// File: rtl/exu_writeback_stage.sv
// execute stage 3, extends load data and registers the gpr, csr and next pc results
`include "exu_config.svh"

module exu_writeback_stage import exu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_valid,
  input  logic [`EXU_XLEN-1:0] i_alu_result,
  input  logic [`EXU_XLEN-1:0] i_next_pc,
  input  logic [`EXU_XLEN-1:0] i_src_a,
  input  logic [`EXU_XLEN-1:0] i_rs2,
  input  logic [`EXU_XLEN-1:0] i_rdata,
  input  mem_op_e              i_mem_op,
  input  logic                 i_mem_to_reg,
  input  ex_ctrl_e             i_ex_ctrl,
  input  logic                 i_invalid_inst,
  input  logic                 i_sel_csr,
  output logic                 o_valid,
  output logic [`EXU_XLEN-1:0] o_gpr_wdata,
  output logic [`EXU_XLEN-1:0] o_csr_wdata,
  output logic [`EXU_XLEN-1:0] o_next_pc,
  output logic                 o_ebreak,
  output logic                 o_abort
);

  localparam int WB = `EXU_WORD_BITS;

  logic [`EXU_XLEN-1:0] load_data;
  logic [`EXU_XLEN-1:0] gpr_wdata;
  logic [`EXU_XLEN-1:0] csr_wdata;

  always_comb begin
    case (i_mem_op)
      mem_lb:  load_data = {{(`EXU_XLEN-8){i_rdata[7]}}, i_rdata[7:0]};
      mem_lbu: load_data = {{(`EXU_XLEN-8){1'b0}}, i_rdata[7:0]};
      mem_lh:  load_data = {{(`EXU_XLEN-16){i_rdata[15]}}, i_rdata[15:0]};
      mem_lhu: load_data = {{(`EXU_XLEN-16){1'b0}}, i_rdata[15:0]};
      mem_lw:  load_data = {{(`EXU_XLEN-WB){i_rdata[WB-1]}}, i_rdata[WB-1:0]};
      mem_lwu: load_data = {{(`EXU_XLEN-WB){1'b0}}, i_rdata[WB-1:0]};
      default: load_data = i_rdata;
    endcase
  end

  // load wins, then the csr read value carried in rs2
  assign gpr_wdata = i_mem_to_reg ? load_data : (i_sel_csr ? i_rs2 : i_alu_result);
  assign csr_wdata = (i_ex_ctrl == ex_csr_write) ? i_src_a : '0;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid     <= 1'b0;
      o_gpr_wdata <= '0;
      o_csr_wdata <= '0;
      o_next_pc   <= '0;
      o_ebreak    <= 1'b0;
      o_abort     <= 1'b0;
    end else begin
      o_valid     <= i_valid;
      o_gpr_wdata <= gpr_wdata;
      o_csr_wdata <= csr_wdata;
      o_next_pc   <= i_next_pc;
      // pulses never leave with a bubble
      o_ebreak    <= i_valid && (i_ex_ctrl == ex_ebreak);
      o_abort     <= i_valid && i_invalid_inst;
    end
  end

endmodule

// File: rtl/exu_top.sv
// execute pipeline top, chains operand select, alu and writeback with a fixed 3 cycle latency
`include "exu_config.svh"

module exu_top import exu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_valid,
  input  logic [`EXU_XLEN-1:0] i_rs1,
  input  logic [`EXU_XLEN-1:0] i_rs2,
  input  logic [`EXU_XLEN-1:0] i_imm,
  input  logic [`EXU_XLEN-1:0] i_pc,
  input  logic                 i_a_from_pc,
  input  b_src_e               i_b_src,
  input  alu_op_e              i_alu_op,
  input  logic                 i_word_cut,
  input  branch_e              i_branch,
  input  mem_op_e              i_mem_op,
  input  logic                 i_mem_to_reg,
  input  logic [`EXU_XLEN-1:0] i_rdata,
  input  ex_ctrl_e             i_ex_ctrl,
  input  logic                 i_invalid_inst,
  input  logic                 i_sel_csr,
  output logic                 o_valid,
  output logic [`EXU_XLEN-1:0] o_gpr_wdata,
  output logic [`EXU_XLEN-1:0] o_csr_wdata,
  output logic [`EXU_XLEN-1:0] o_next_pc,
  output logic                 o_ebreak,
  output logic                 o_abort
);

  // -------------------------------------------------
  // stage 1 to stage 2
  // -------------------------------------------------
  logic                 s1_valid;
  logic [`EXU_XLEN-1:0] s1_src_a;
  logic [`EXU_XLEN-1:0] s1_src_b;
  logic [`EXU_XLEN-1:0] s1_rs1;
  logic [`EXU_XLEN-1:0] s1_rs2;
  logic [`EXU_XLEN-1:0] s1_imm;
  logic [`EXU_XLEN-1:0] s1_pc;
  logic [`EXU_XLEN-1:0] s1_rdata;
  alu_op_e              s1_alu_op;
  logic                 s1_word_cut;
  branch_e              s1_branch;
  mem_op_e              s1_mem_op;
  logic                 s1_mem_to_reg;
  ex_ctrl_e             s1_ex_ctrl;
  logic                 s1_invalid_inst;
  logic                 s1_sel_csr;

  // -------------------------------------------------
  // stage 2 to stage 3
  // -------------------------------------------------
  logic                 s2_valid;
  logic [`EXU_XLEN-1:0] s2_alu_result;
  logic [`EXU_XLEN-1:0] s2_next_pc;
  logic [`EXU_XLEN-1:0] s2_src_a;
  logic [`EXU_XLEN-1:0] s2_rs2;
  logic [`EXU_XLEN-1:0] s2_rdata;
  mem_op_e              s2_mem_op;
  logic                 s2_mem_to_reg;
  ex_ctrl_e             s2_ex_ctrl;
  logic                 s2_invalid_inst;
  logic                 s2_sel_csr;

  exu_operand_stage u_operand (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(i_valid),
    .i_rs1(i_rs1), .i_rs2(i_rs2), .i_imm(i_imm), .i_pc(i_pc),
    .i_a_from_pc(i_a_from_pc), .i_b_src(i_b_src), .i_word_cut(i_word_cut),
    .i_alu_op(i_alu_op), .i_branch(i_branch), .i_mem_op(i_mem_op),
    .i_mem_to_reg(i_mem_to_reg), .i_rdata(i_rdata), .i_ex_ctrl(i_ex_ctrl),
    .i_invalid_inst(i_invalid_inst), .i_sel_csr(i_sel_csr),
    .o_valid(s1_valid), .o_src_a(s1_src_a), .o_src_b(s1_src_b),
    .o_rs1(s1_rs1), .o_rs2(s1_rs2), .o_imm(s1_imm), .o_pc(s1_pc),
    .o_rdata(s1_rdata), .o_alu_op(s1_alu_op), .o_word_cut(s1_word_cut),
    .o_branch(s1_branch), .o_mem_op(s1_mem_op), .o_mem_to_reg(s1_mem_to_reg),
    .o_ex_ctrl(s1_ex_ctrl), .o_invalid_inst(s1_invalid_inst), .o_sel_csr(s1_sel_csr)
  );

  exu_alu_stage u_alu (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(s1_valid),
    .i_src_a(s1_src_a), .i_src_b(s1_src_b), .i_rs1(s1_rs1), .i_rs2(s1_rs2),
    .i_imm(s1_imm), .i_pc(s1_pc), .i_rdata(s1_rdata),
    .i_alu_op(s1_alu_op), .i_word_cut(s1_word_cut), .i_branch(s1_branch),
    .i_mem_op(s1_mem_op), .i_mem_to_reg(s1_mem_to_reg), .i_ex_ctrl(s1_ex_ctrl),
    .i_invalid_inst(s1_invalid_inst), .i_sel_csr(s1_sel_csr),
    .o_valid(s2_valid), .o_alu_result(s2_alu_result), .o_next_pc(s2_next_pc),
    .o_src_a(s2_src_a), .o_rs2(s2_rs2), .o_rdata(s2_rdata),
    .o_mem_op(s2_mem_op), .o_mem_to_reg(s2_mem_to_reg), .o_ex_ctrl(s2_ex_ctrl),
    .o_invalid_inst(s2_invalid_inst), .o_sel_csr(s2_sel_csr)
  );

  exu_writeback_stage u_wb (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(s2_valid),
    .i_alu_result(s2_alu_result), .i_next_pc(s2_next_pc), .i_src_a(s2_src_a),
    .i_rs2(s2_rs2), .i_rdata(s2_rdata), .i_mem_op(s2_mem_op),
    .i_mem_to_reg(s2_mem_to_reg), .i_ex_ctrl(s2_ex_ctrl),
    .i_invalid_inst(s2_invalid_inst), .i_sel_csr(s2_sel_csr),
    .o_valid(o_valid), .o_gpr_wdata(o_gpr_wdata), .o_csr_wdata(o_csr_wdata),
    .o_next_pc(o_next_pc), .o_ebreak(o_ebreak), .o_abort(o_abort)
  );

endmodule

// File: test/exu_clock_gen.sv
// testbench clock source, free running with a period of 100 time units
module exu_clock_gen #(
  parameter int HALF_PERIOD = 50
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always #HALF_PERIOD o_clk = ~o_clk;

endmodule

// File: test/exu_sva.sv
// assertion checker bound to the execute top, compares outputs with a 3 deep model history
`include "exu_config.svh"

module exu_sva import exu_pkg::*; (
  input logic                 i_clk,
  input logic                 i_rst_n,
  input logic                 i_valid,
  input logic [`EXU_XLEN-1:0] i_rs1,
  input logic [`EXU_XLEN-1:0] i_rs2,
  input logic [`EXU_XLEN-1:0] i_imm,
  input logic [`EXU_XLEN-1:0] i_pc,
  input logic                 i_a_from_pc,
  input b_src_e               i_b_src,
  input alu_op_e              i_alu_op,
  input logic                 i_word_cut,
  input branch_e              i_branch,
  input mem_op_e              i_mem_op,
  input logic                 i_mem_to_reg,
  input logic [`EXU_XLEN-1:0] i_rdata,
  input ex_ctrl_e             i_ex_ctrl,
  input logic                 i_invalid_inst,
  input logic                 i_sel_csr,
  input logic                 o_valid,
  input logic [`EXU_XLEN-1:0] o_gpr_wdata,
  input logic [`EXU_XLEN-1:0] o_csr_wdata,
  input logic [`EXU_XLEN-1:0] o_next_pc,
  input logic                 o_ebreak,
  input logic                 o_abort
);

  int fail_count = 0;

  logic [63:0] a_in;
  logic [63:0] b_in;
  logic [63:0] gpr_in;
  logic [63:0] csr_in;
  logic [63:0] pc_in;
  logic [63:0] e_gpr [3];
  logic [63:0] e_csr [3];
  logic [63:0] e_pc [3];
  logic        e_valid [3];
  logic        e_ebreak [3];
  logic        e_abort [3];

  function automatic logic [63:0] sext32(input logic [63:0] v);
    return {{32{v[31]}}, v[31:0]};
  endfunction

  function automatic logic [63:0] low_word(input logic [63:0] v, input logic cut);
    return cut ? {32'b0, v[31:0]} : v;
  endfunction

  function automatic logic [63:0] alu_ref(input logic [63:0] a, input logic [63:0] b,
                                          input alu_op_e op, input logic cut);
    logic [5:0]  sh;
    logic [63:0] r;
    sh = cut ? {1'b0, b[4:0]} : b[5:0];
    case (op)
      alu_add:    r = a + b;
      alu_sub:    r = a - b;
      alu_sll:    r = a << sh;
      alu_slt:    r = {63'b0, $signed(a) < $signed(b)};
      alu_sltu:   r = {63'b0, a < b};
      alu_xor:    r = a ^ b;
      alu_srl:    r = a >> sh;
      // sraw fills from bit 31 of A
      alu_sra:    r = cut ? ($signed(sext32(a)) >>> sh) : ($signed(a) >>> sh);
      alu_or:     r = a | b;
      alu_and:    r = a & b;
      alu_copy_b: r = b;
      default:    r = 64'b0;
    endcase
    return cut ? sext32(r) : r;
  endfunction

  function automatic logic [63:0] next_pc_ref(input branch_e br, input logic [63:0] a,
                                              input logic [63:0] b, input logic [63:0] rs1,
                                              input logic [63:0] imm, input logic [63:0] pc);
    logic eq;
    logic lt;
    eq = (a == b);
    lt = $signed(a) < $signed(b);
    case (br)
      br_jal:  return pc + imm;
      br_jalr: return (rs1 + imm) & ~64'd1;
      br_beq:  return eq ? pc + imm : pc + 64'd4;
      br_bne:  return !eq ? pc + imm : pc + 64'd4;
      br_blt:  return lt ? pc + imm : pc + 64'd4;
      br_bge:  return !lt ? pc + imm : pc + 64'd4;
      default: return pc + 64'd4;
    endcase
  endfunction

  function automatic logic [63:0] load_ref(input mem_op_e op, input logic [63:0] d);
    case (op)
      mem_lb:  return {{56{d[7]}}, d[7:0]};
      mem_lbu: return {56'b0, d[7:0]};
      mem_lh:  return {{48{d[15]}}, d[15:0]};
      mem_lhu: return {48'b0, d[15:0]};
      mem_lw:  return sext32(d);
      mem_lwu: return {32'b0, d[31:0]};
      default: return d;
    endcase
  endfunction

  always_comb begin
    a_in = i_a_from_pc ? i_pc : low_word(i_rs1, i_word_cut);
    case (i_b_src)
      b_src_imm:     b_in = low_word(i_imm, i_word_cut);
      b_src_pc_step: b_in = 64'd4;
      default:       b_in = low_word(i_rs2, i_word_cut);
    endcase
    if (i_mem_to_reg) begin
      gpr_in = load_ref(i_mem_op, i_rdata);
    end else if (i_sel_csr) begin
      gpr_in = i_rs2;
    end else begin
      gpr_in = alu_ref(a_in, b_in, i_alu_op, i_word_cut);
    end
    csr_in = (i_ex_ctrl == ex_csr_write) ? a_in : 64'b0;
    pc_in = next_pc_ref(i_branch, a_in, b_in, i_rs1, i_imm, i_pc);
  end

  // model history, one entry per pipeline register
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 0; k < 3; k++) begin
        e_gpr[k]    <= '0;
        e_csr[k]    <= '0;
        e_pc[k]     <= '0;
        e_valid[k]  <= 1'b0;
        e_ebreak[k] <= 1'b0;
        e_abort[k]  <= 1'b0;
      end
    end else begin
      e_gpr[0]    <= gpr_in;
      e_csr[0]    <= csr_in;
      e_pc[0]     <= pc_in;
      e_valid[0]  <= i_valid;
      e_ebreak[0] <= i_valid && (i_ex_ctrl == ex_ebreak);
      e_abort[0]  <= i_valid && i_invalid_inst;
      for (int k = 1; k < 3; k++) begin
        e_gpr[k]    <= e_gpr[k-1];
        e_csr[k]    <= e_csr[k-1];
        e_pc[k]     <= e_pc[k-1];
        e_valid[k]  <= e_valid[k-1];
        e_ebreak[k] <= e_ebreak[k-1];
        e_abort[k]  <= e_abort[k-1];
      end
    end
  end

  // ------------------------------------------------
  // output checks
  // ------------------------------------------------
  a_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !o_valid && !o_ebreak &&
      !o_abort && o_gpr_wdata == '0 && o_csr_wdata == '0 && o_next_pc == '0)
    else begin
      fail_count++;
      $error(
        "Fail exp 0 o_valid %h o_ebreak %h o_abort %h o_gpr_wdata %h o_csr_wdata %h o_next_pc %h",
        o_valid, o_ebreak, o_abort, o_gpr_wdata, o_csr_wdata, o_next_pc);
    end

  a_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_valid == e_valid[2])
    else begin
      fail_count++;
      $error("Fail o_valid exp %h got %h", e_valid[2], o_valid);
    end

  a_gpr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      e_valid[2] |-> o_gpr_wdata == e_gpr[2])
    else begin
      fail_count++;
      $error("Fail o_gpr_wdata exp %h got %h", e_gpr[2], o_gpr_wdata);
    end

  a_csr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      e_valid[2] |-> o_csr_wdata == e_csr[2])
    else begin
      fail_count++;
      $error("Fail o_csr_wdata exp %h got %h", e_csr[2], o_csr_wdata);
    end

  a_next_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      e_valid[2] |-> o_next_pc == e_pc[2])
    else begin
      fail_count++;
      $error("Fail o_next_pc exp %h got %h", e_pc[2], o_next_pc);
    end

  a_ebreak: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_ebreak == e_ebreak[2])
    else begin
      fail_count++;
      $error("Fail o_ebreak exp %h got %h", e_ebreak[2], o_ebreak);
    end

  a_abort: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_abort == e_abort[2])
    else begin
      fail_count++;
      $error("Fail o_abort exp %h got %h", e_abort[2], o_abort);
    end

endmodule

// File: test/exu_tb.sv
// testbench top for the execute pipeline, drives lcg stimulus while bound assertions check
`include "exu_config.svh"

module exu_tb import exu_pkg::*;;

  localparam int MAX_CYCLES = 600;
  localparam alu_op_e ALU_OPS [11] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and, alu_copy_b};
  localparam branch_e BR_KINDS [7] = '{br_none, br_jal, br_jalr, br_beq, br_bne,
    br_blt, br_bge};
  localparam mem_op_e MEM_OPS [7] = '{mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw,
    mem_lwu, mem_ld};
  localparam ex_ctrl_e EX_CTRLS [3] = '{ex_none, ex_csr_write, ex_ebreak};
  localparam b_src_e B_SRCS [3] = '{b_src_rs2, b_src_imm, b_src_pc_step};

  logic                 i_clk;
  logic                 i_rst_n;
  logic                 i_valid;
  logic [`EXU_XLEN-1:0] i_rs1;
  logic [`EXU_XLEN-1:0] i_rs2;
  logic [`EXU_XLEN-1:0] i_imm;
  logic [`EXU_XLEN-1:0] i_pc;
  logic                 i_a_from_pc;
  b_src_e               i_b_src;
  alu_op_e              i_alu_op;
  logic                 i_word_cut;
  branch_e              i_branch;
  mem_op_e              i_mem_op;
  logic                 i_mem_to_reg;
  logic [`EXU_XLEN-1:0] i_rdata;
  ex_ctrl_e             i_ex_ctrl;
  logic                 i_invalid_inst;
  logic                 i_sel_csr;
  logic                 o_valid;
  logic [`EXU_XLEN-1:0] o_gpr_wdata;
  logic [`EXU_XLEN-1:0] o_csr_wdata;
  logic [`EXU_XLEN-1:0] o_next_pc;
  logic                 o_ebreak;
  logic                 o_abort;

  logic [31:0] lcg_state = 32'd78118;
  int          cycles = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          base_fails;
  logic [63:0] r;

  exu_clock_gen u_clk (.o_clk(i_clk));

  exu_top u_dut (.*);

  bind exu_top exu_sva u_sva (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    hi = lcg_next();
    return {hi, lcg_next()};
  endfunction

  // next edge, random data and a plain alu instruction as the baseline
  task automatic start_instr(input logic v);
    @(posedge i_clk);
    i_valid        <= v;
    i_rs1          <= rand64();
    i_rs2          <= rand64();
    i_imm          <= rand64();
    i_pc           <= rand64() & ~64'd3;
    i_rdata        <= rand64();
    i_a_from_pc    <= 1'b0;
    i_b_src        <= b_src_rs2;
    i_alu_op       <= alu_add;
    i_word_cut     <= 1'b0;
    i_branch       <= br_none;
    i_mem_op       <= mem_ld;
    i_mem_to_reg   <= 1'b0;
    i_ex_ctrl      <= ex_none;
    i_invalid_inst <= 1'b0;
    i_sel_csr      <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    int fails;
    @(posedge i_clk);
    i_valid <= 1'b0;
    repeat (4) @(posedge i_clk);
    fails = u_dut.u_sva.fail_count - base_fails;
    $display("%s: %0d failures", name, fails);
    if (fails == 0) tests_passed++;
    else tests_failed++;
    base_fails = u_dut.u_sva.fail_count;
  endtask

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: tests did not finish");
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    i_rs1 = '0;
    i_rs2 = '0;
    i_imm = '0;
    i_pc = '0;
    i_a_from_pc = 1'b0;
    i_b_src = b_src_rs2;
    i_alu_op = alu_add;
    i_word_cut = 1'b0;
    i_branch = br_none;
    i_mem_op = mem_ld;
    i_mem_to_reg = 1'b0;
    i_rdata = '0;
    i_ex_ctrl = ex_none;
    i_invalid_inst = 1'b0;
    i_sel_csr = 1'b0;
    base_fails = 0;
    repeat (2) @(posedge i_clk);
    i_rst_n <= 1'b1;

    // ------------------------------------------------
    // reset and idle bubbles carrying pulse requests
    // ------------------------------------------------
    for (int i = 0; i < 8; i++) begin
      start_instr(1'b0);
      i_ex_ctrl      <= ex_ebreak;
      i_invalid_inst <= 1'b1;
    end
    finish_test("reset");

    for (int i = 0; i < 66; i++) begin
      start_instr(1'b1);
      i_alu_op    <= ALU_OPS[i % 11];
      i_word_cut  <= (i / 11) % 2 == 1;
      i_b_src     <= B_SRCS[(i / 22) % 3];
      i_a_from_pc <= lcg_next() % 5 == 0;
    end
    finish_test("alu");

    for (int i = 0; i < 64; i++) begin
      start_instr(1'b1);
      r = rand64();
      i_branch <= BR_KINDS[i % 7];
      i_rs1    <= r;
      // equal or smaller rs2 about half the time
      case (lcg_next() % 4)
        0: i_rs2 <= r;
        1: i_rs2 <= r - 64'(lcg_next() % 16 + 1);
        default: i_rs2 <= rand64();
      endcase
    end
    finish_test("branch");

    for (int i = 0; i < 64; i++) begin
      start_instr(1'b1);
      i_mem_op     <= MEM_OPS[i % 7];
      i_mem_to_reg <= i % 4 != 3;
      i_sel_csr    <= i % 4 == 3;
    end
    finish_test("load");

    for (int i = 0; i < 64; i++) begin
      start_instr(1'b1);
      i_ex_ctrl      <= EX_CTRLS[i % 3];
      i_invalid_inst <= i % 5 == 0;
      i_a_from_pc    <= lcg_next() % 2 == 1;
      i_word_cut     <= lcg_next() % 2 == 1;
    end
    finish_test("control");

    for (int i = 0; i < 64; i++) begin
      start_instr(lcg_next() % 3 != 0);
      i_alu_op       <= ALU_OPS[lcg_next() % 11];
      i_branch       <= BR_KINDS[lcg_next() % 7];
      i_mem_op       <= MEM_OPS[lcg_next() % 7];
      i_b_src        <= B_SRCS[lcg_next() % 3];
      i_ex_ctrl      <= EX_CTRLS[lcg_next() % 3];
      i_word_cut     <= lcg_next() % 2 == 1;
      i_mem_to_reg   <= lcg_next() % 3 == 0;
      i_sel_csr      <= lcg_next() % 3 == 0;
      i_invalid_inst <= lcg_next() % 4 == 0;
    end
    finish_test("mixed");

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_operand_stage.sv
rtl/exu_alu_stage.sv
rtl/exu_writeback_stage.sv
rtl/exu_top.sv
test/exu_clock_gen.sv
test/exu_sva.sv
test/exu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the execute pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f vlog.f --top-module exu_tb \
  --Mdir obj_dir -o exu_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/exu_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
